// File: src/rob_pkg.sv
package rob_pkg;

    // =========================================================================
    // Sizes
    // =========================================================================

    // Number of entries, must stay a power of two
    localparam int ROB_DEPTH = 16;
    localparam int SLOT_W = 4;
    // Slot index plus wrap bit
    localparam int PTR_W = 5;
    localparam int DATA_W = 32;
    // Architectural destination register number
    localparam int DEST_W = 5;

    // Lane counts per interface
    localparam int ALLOC_LANES = 2;
    localparam int CDB_PORTS = 2;
    localparam int COMMIT_LANES = 2;

    // =========================================================================
    // Types
    // =========================================================================

    typedef logic [SLOT_W-1:0] slot_t;
    typedef logic [PTR_W-1:0] ptr_t;
    // Occupancy 0..ROB_DEPTH, same width as a pointer
    typedef logic [PTR_W-1:0] count_t;

    // One allocation lane from rename
    typedef struct packed {
        logic              valid;
        logic [DEST_W-1:0] dest;
    } alloc_req_t;

    // One result-bus port
    typedef struct packed {
        logic              valid;
        slot_t             slot;
        logic [DATA_W-1:0] data;
        logic              exception;
    } cdb_t;

    // Stored buffer entry
    typedef struct packed {
        logic              executed;
        logic              exception;
        logic [DEST_W-1:0] dest;
        logic [DATA_W-1:0] data;
    } entry_t;

    // One retiring instruction
    typedef struct packed {
        logic              valid;
        logic [DEST_W-1:0] dest;
        logic [DATA_W-1:0] data;
        logic              exception;
    } commit_t;

endpackage

// File: src/rob_alloc_ctrl.sv
module rob_alloc_ctrl (
    input  logic                                           clk,
    input  logic                                           reset,

    // Allocation requests from rename
    input  rob_pkg::alloc_req_t [rob_pkg::ALLOC_LANES-1:0] alloc_req,
    // Head pointer from the commit side
    input  rob_pkg::ptr_t                                  head,

    output logic                                           alloc_ok,
    output rob_pkg::slot_t [rob_pkg::ALLOC_LANES-1:0]      alloc_slot,
    output logic [rob_pkg::ALLOC_LANES-1:0]                alloc_we,

    // Occupancy status
    output rob_pkg::count_t                                count,
    output logic                                           empty,
    output logic                                           full
);

    // =========================================================================
    // Tail pointer and occupancy
    // =========================================================================

    rob_pkg::ptr_t   tail;
    rob_pkg::count_t free_cnt;
    rob_pkg::count_t num_req;

    // Wrap bit makes tail - head exact for 0..ROB_DEPTH
    assign count    = tail - head;
    assign free_cnt = rob_pkg::count_t'(rob_pkg::ROB_DEPTH) - count;

    assign empty = (count == '0);
    assign full  = (count == rob_pkg::count_t'(rob_pkg::ROB_DEPTH));

    // =========================================================================
    // Group accept and slot assignment
    // =========================================================================

    // Number of lanes asking for a slot
    always_comb begin
        num_req = '0;
        for (int i = 0; i < rob_pkg::ALLOC_LANES; i++) begin
            num_req = num_req + rob_pkg::count_t'(alloc_req[i].valid);
        end
    end

    // All or nothing, also high when no lane requests
    assign alloc_ok = (num_req <= free_cnt);

    // Consecutive slots from the tail, invalid lanes do not consume one
    always_comb begin
        rob_pkg::slot_t next_slot;

        next_slot = tail[rob_pkg::SLOT_W-1:0];
        for (int i = 0; i < rob_pkg::ALLOC_LANES; i++) begin
            alloc_slot[i] = next_slot;
            // Store write only for accepted, valid lanes
            alloc_we[i]   = alloc_req[i].valid && alloc_ok;
            next_slot     = next_slot + rob_pkg::slot_t'(alloc_req[i].valid);
        end
    end

    // Tail moves by the whole group on accept
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            tail <= '0;
        end else if (alloc_ok) begin
            tail <= tail + num_req;
        end
    end

endmodule

// File: src/rob_entry_store.sv
module rob_entry_store (
    input  logic                                           clk,
    input  logic                                           reset,

    // Allocation writes, already qualified by accept
    input  logic [rob_pkg::ALLOC_LANES-1:0]                alloc_we,
    input  rob_pkg::slot_t [rob_pkg::ALLOC_LANES-1:0]      alloc_slot,
    input  rob_pkg::alloc_req_t [rob_pkg::ALLOC_LANES-1:0] alloc_req,

    // Result-bus writes
    input  rob_pkg::cdb_t [rob_pkg::CDB_PORTS-1:0]         cdb,

    // Head read address
    input  rob_pkg::ptr_t                                  head,
    output rob_pkg::entry_t [rob_pkg::COMMIT_LANES-1:0]    head_entry
);

    // =========================================================================
    // Entry storage
    // =========================================================================

    rob_pkg::entry_t entries [rob_pkg::ROB_DEPTH];

    // Write order sets priority
    // Later NBAs override earlier ones on the same slot
    //   allocation clear < result port 0 < result port 1
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else begin
            // New entries start not executed, destination recorded
            for (int i = 0; i < rob_pkg::ALLOC_LANES; i++) begin
                if (alloc_we[i]) begin
                    entries[alloc_slot[i]] <= '{
                        executed:  1'b0,
                        exception: 1'b0,
                        dest:      alloc_req[i].dest,
                        data:      '0
                    };
                end
            end

            // Results fill data and flag, dest kept
            for (int p = 0; p < rob_pkg::CDB_PORTS; p++) begin
                if (cdb[p].valid) begin
                    entries[cdb[p].slot].executed  <= 1'b1;
                    entries[cdb[p].slot].exception <= cdb[p].exception;
                    entries[cdb[p].slot].data      <= cdb[p].data;
                end
            end
        end
    end

    // =========================================================================
    // Head read ports
    // =========================================================================

    // Head, head+1, ... with wraparound in slot width
    always_comb begin
        rob_pkg::slot_t rd_slot;

        rd_slot = head[rob_pkg::SLOT_W-1:0];
        for (int i = 0; i < rob_pkg::COMMIT_LANES; i++) begin
            head_entry[i] = entries[rd_slot];
            rd_slot       = rd_slot + 1'b1;
        end
    end

endmodule

// File: src/rob_commit_ctrl.sv
module rob_commit_ctrl (
    input  logic                                        clk,
    input  logic                                        reset,

    // Entries at head and head+1
    input  rob_pkg::entry_t [rob_pkg::COMMIT_LANES-1:0] head_entry,
    // Current occupancy
    input  rob_pkg::count_t                             count,

    output rob_pkg::ptr_t                               head,
    output rob_pkg::commit_t [rob_pkg::COMMIT_LANES-1:0] commit
);

    // =========================================================================
    // In-order readiness
    // =========================================================================

    rob_pkg::ptr_t num_commit;

    // Lane i needs more than i entries and every older lane ready
    always_comb begin
        logic chain;

        chain      = 1'b1;
        num_commit = '0;
        for (int i = 0; i < rob_pkg::COMMIT_LANES; i++) begin
            chain = chain && head_entry[i].executed &&
                    (count > rob_pkg::count_t'(i));

            commit[i].valid     = chain;
            commit[i].dest      = head_entry[i].dest;
            commit[i].data      = head_entry[i].data;
            commit[i].exception = head_entry[i].exception;

            num_commit = num_commit + rob_pkg::ptr_t'(chain);
        end
    end

    // =========================================================================
    // Head pointer
    // =========================================================================

    // No back-pressure, every valid lane retires at this edge
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            head <= '0;
        end else begin
            head <= head + num_commit;
        end
    end

endmodule

// File: src/rob_top.sv
module rob_top (
    input  logic                                            clk,
    input  logic                                            reset,

    // Allocation from rename
    input  rob_pkg::alloc_req_t [rob_pkg::ALLOC_LANES-1:0]  alloc_req,
    output logic                                            alloc_ok,
    output rob_pkg::slot_t [rob_pkg::ALLOC_LANES-1:0]       alloc_slot,

    // Results from execution units
    input  rob_pkg::cdb_t [rob_pkg::CDB_PORTS-1:0]          cdb,

    // Retirement
    output rob_pkg::commit_t [rob_pkg::COMMIT_LANES-1:0]    commit,

    // Status
    output rob_pkg::count_t                                 count,
    output logic                                            empty,
    output logic                                            full
);

    // =========================================================================
    // Internal wiring
    // =========================================================================

    rob_pkg::ptr_t                                head;
    logic [rob_pkg::ALLOC_LANES-1:0]              alloc_we;
    rob_pkg::entry_t [rob_pkg::COMMIT_LANES-1:0]  head_entry;

    // Producer side, tail and accept
    rob_alloc_ctrl u_alloc_ctrl (
        .clk        (clk),
        .reset      (reset),
        .alloc_req  (alloc_req),
        .head       (head),
        .alloc_ok   (alloc_ok),
        .alloc_slot (alloc_slot),
        .alloc_we   (alloc_we),
        .count      (count),
        .empty      (empty),
        .full       (full)
    );

    // Entry array
    rob_entry_store u_entry_store (
        .clk        (clk),
        .reset      (reset),
        .alloc_we   (alloc_we),
        .alloc_slot (alloc_slot),
        .alloc_req  (alloc_req),
        .cdb        (cdb),
        .head       (head),
        .head_entry (head_entry)
    );

    // Consumer side, head and retire
    rob_commit_ctrl u_commit_ctrl (
        .clk        (clk),
        .reset      (reset),
        .head_entry (head_entry),
        .count      (count),
        .head       (head),
        .commit     (commit)
    );

endmodule

// File: tests/rob_properties.sv
module rob_properties (
    input  logic                                         clk,
    input  logic                                         reset,
    input  rob_pkg::commit_t [rob_pkg::COMMIT_LANES-1:0] commit,
    input  rob_pkg::count_t                              count,
    input  logic                                         empty,
    input  logic                                         full
);

    // Failures seen so far, read by the testbench
    int fail_cnt = 0;

    // =========================================================================
    // Commit lanes and occupancy
    // =========================================================================

    // Lane 1 only behind lane 0
    a_lane_order: assert property (@(posedge clk) disable iff (!reset)
        commit[1].valid |-> commit[0].valid)
        else begin
            $error("commit lane 1 valid while lane 0 is not");
            fail_cnt++;
        end

    a_full_empty: assert property (@(posedge clk) disable iff (!reset)
        !(full && empty))
        else begin
            $error("full and empty high together");
            fail_cnt++;
        end

    a_count_range: assert property (@(posedge clk) disable iff (!reset)
        count <= rob_pkg::count_t'(rob_pkg::ROB_DEPTH))
        else begin
            $error("count above buffer depth");
            fail_cnt++;
        end

    // Nothing to retire from an empty buffer
    a_empty_no_commit: assert property (@(posedge clk) disable iff (!reset)
        empty |-> !(commit[0].valid || commit[1].valid))
        else begin
            $error("commit valid while empty");
            fail_cnt++;
        end

endmodule

bind rob_top rob_properties u_props (
    .clk      (clk),
    .reset    (reset),
    .commit   (commit),
    .count    (count),
    .empty    (empty),
    .full     (full)
);

// File: tests/tb_rob.sv
module tb_rob;

    // =========================================================================
    // Run limits
    // =========================================================================

    localparam int RESET_LEN = 16;
    localparam int RANDOM_LEN = 800;
    localparam int HOL_LEN = 60;
    localparam int FULL_LEN = 80;
    localparam int GROUP_LEN = 80;
    localparam int OCC_LEN = 300;
    // Twice the summed test lengths
    localparam int TIMEOUT_CYCLES =
        2 * (RESET_LEN + RANDOM_LEN + HOL_LEN + FULL_LEN + GROUP_LEN + OCC_LEN);

    logic                                           clk;
    logic                                           reset;
    rob_pkg::alloc_req_t [rob_pkg::ALLOC_LANES-1:0] alloc_req;
    logic                                           alloc_ok;
    rob_pkg::slot_t [rob_pkg::ALLOC_LANES-1:0]      alloc_slot;
    rob_pkg::cdb_t [rob_pkg::CDB_PORTS-1:0]         cdb;
    rob_pkg::commit_t [rob_pkg::COMMIT_LANES-1:0]   commit;
    rob_pkg::count_t                                count;
    logic                                           empty;
    logic                                           full;

    int          n_checks = 0;
    int          n_errors = 0;
    int          cycle_cnt = 0;
    logic [31:0] lfsr_state = 32'h1c10;

    // Reference model, slots oldest first plus per-slot contents
    int                          m_q [$];
    int                          m_tail = 0;
    logic                        m_exec [rob_pkg::ROB_DEPTH];
    logic                        m_exc  [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::DEST_W-1:0]  m_dest [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::DATA_W-1:0]  m_data [rob_pkg::ROB_DEPTH];

    rob_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .alloc_req  (alloc_req),
        .alloc_ok   (alloc_ok),
        .alloc_slot (alloc_slot),
        .cdb        (cdb),
        .commit     (commit),
        .count      (count),
        .empty      (empty),
        .full       (full)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    // =========================================================================
    // Helpers
    // =========================================================================

    // Galois LFSR, one step per bit
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // Random destination register number
    function automatic logic [rob_pkg::DEST_W-1:0] rand_dest();
        logic [31:0] v;
        v = rand_bits(rob_pkg::DEST_W);
        return v[rob_pkg::DEST_W-1:0];
    endfunction

    task automatic compare_value(string name, logic [63:0] got, logic [63:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Expected commit lane from the in-order rule
    function automatic rob_pkg::commit_t ref_commit(int lane);
        rob_pkg::commit_t c;
        logic ready;
        c = '0;
        ready = 1'b1;
        for (int i = 0; i <= lane; i++) begin
            if (i >= m_q.size()) begin
                ready = 1'b0;
            end else if (!m_exec[m_q[i]]) begin
                ready = 1'b0;
            end
        end
        if (ready) begin
            c.valid     = 1'b1;
            c.dest      = m_dest[m_q[lane]];
            c.data      = m_data[m_q[lane]];
            c.exception = m_exc[m_q[lane]];
        end
        return c;
    endfunction

    task automatic idle_inputs();
        alloc_req = '0;
        cdb = '0;
    endtask

    task automatic send_result(int port, int slot);
        cdb[port].valid     = 1'b1;
        cdb[port].slot      = rob_pkg::slot_t'(slot);
        cdb[port].data      = rand_bits(32);
        // Roughly one result in four raises an exception
        cdb[port].exception = lfsr_bit() & lfsr_bit();
    endtask

    // Results for random outstanding slots, at most one per port
    task automatic send_results(bit always_send);
        int cand [$];
        int idx;
        foreach (m_q[i]) begin
            if (!m_exec[m_q[i]]) begin
                cand.push_back(m_q[i]);
            end
        end
        for (int p = 0; p < rob_pkg::CDB_PORTS; p++) begin
            if (cand.size() > 0 && (always_send || lfsr_bit())) begin
                idx = int'(rand_bits(4)) % cand.size();
                send_result(p, cand[idx]);
                cand.delete(idx);
            end
        end
    endtask

    // Fill from a state with enough room, two per cycle
    task automatic allocate(int n);
        int left;
        left = n;
        while (left > 0) begin
            @(negedge clk);
            idle_inputs();
            alloc_req[0] = '{valid: 1'b1, dest: rand_dest()};
            left--;
            if (left > 0) begin
                alloc_req[1] = '{valid: 1'b1, dest: rand_dest()};
                left--;
            end
        end
        @(negedge clk);
        idle_inputs();
    endtask

    task automatic drain();
        while (m_q.size() != 0) begin
            @(negedge clk);
            idle_inputs();
            send_results(1'b1);
        end
    endtask

    task automatic report_test(string name, int err_start);
        $display("Test %s finished with %0d errors", name, n_errors - err_start);
    endtask

    // =========================================================================
    // Comparison and model update
    // =========================================================================

    always @(posedge clk) begin
        rob_pkg::commit_t exp_c [rob_pkg::COMMIT_LANES];
        int   exp_cnt;
        int   nreq;
        int   s;
        logic exp_ok;

        if (reset) begin
            exp_cnt = m_q.size();
            compare_value("count", count, exp_cnt);
            compare_value("empty", empty, exp_cnt == 0);
            compare_value("full", full, exp_cnt == rob_pkg::ROB_DEPTH);

            nreq = 0;
            for (int i = 0; i < rob_pkg::ALLOC_LANES; i++) begin
                nreq += int'(alloc_req[i].valid);
            end
            exp_ok = (nreq <= rob_pkg::ROB_DEPTH - exp_cnt);
            compare_value("alloc_ok", alloc_ok, exp_ok);

            // Slot numbers only matter for valid lanes
            s = m_tail;
            for (int i = 0; i < rob_pkg::ALLOC_LANES; i++) begin
                if (alloc_req[i].valid) begin
                    compare_value($sformatf("alloc_slot[%0d]", i), alloc_slot[i], s);
                    s = (s + 1) % rob_pkg::ROB_DEPTH;
                end
            end

            for (int i = 0; i < rob_pkg::COMMIT_LANES; i++) begin
                exp_c[i] = ref_commit(i);
                if (exp_c[i].valid) begin
                    compare_value($sformatf("commit[%0d]", i), commit[i], exp_c[i]);
                end else begin
                    compare_value($sformatf("commit[%0d].valid", i), commit[i].valid, 1'b0);
                end
            end

            // Retire, then allocate, then results on top
            for (int i = 0; i < rob_pkg::COMMIT_LANES; i++) begin
                if (exp_c[i].valid) begin
                    void'(m_q.pop_front());
                end
            end
            if (exp_ok) begin
                for (int i = 0; i < rob_pkg::ALLOC_LANES; i++) begin
                    if (alloc_req[i].valid) begin
                        m_exec[m_tail] = 1'b0;
                        m_exc[m_tail]  = 1'b0;
                        m_data[m_tail] = '0;
                        m_dest[m_tail] = alloc_req[i].dest;
                        m_q.push_back(m_tail);
                        m_tail = (m_tail + 1) % rob_pkg::ROB_DEPTH;
                    end
                end
            end
            // Port 1 applied last, so it wins a shared slot
            for (int p = 0; p < rob_pkg::CDB_PORTS; p++) begin
                if (cdb[p].valid) begin
                    m_exec[cdb[p].slot] = 1'b1;
                    m_data[cdb[p].slot] = cdb[p].data;
                    m_exc[cdb[p].slot]  = cdb[p].exception;
                end
            end
        end
    end

    // =========================================================================
    // Test sequence
    // =========================================================================

    initial begin
        int err_start;
        int exp_tail;

        idle_inputs();
        reset = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b1;

        // Reset state
        err_start = n_errors;
        repeat (4) begin
            @(negedge clk);
            compare_value("empty", empty, 1'b1);
            compare_value("full", full, 1'b0);
            compare_value("count", count, 0);
            compare_value("commit[0].valid", commit[0].valid, 1'b0);
            compare_value("commit[1].valid", commit[1].valid, 1'b0);
        end
        report_test("reset_state", err_start);

        // Random traffic, results out of order
        err_start = n_errors;
        repeat (RANDOM_LEN) begin
            @(negedge clk);
            idle_inputs();
            for (int i = 0; i < rob_pkg::ALLOC_LANES; i++) begin
                alloc_req[i].valid = lfsr_bit();
                alloc_req[i].dest  = rand_dest();
            end
            send_results(1'b0);
        end
        drain();
        report_test("in_order_commit", err_start);

        // Younger entries done, head still waiting
        err_start = n_errors;
        allocate(4);
        send_result(0, m_q[2]);
        send_result(1, m_q[3]);
        repeat (3) begin
            @(negedge clk);
            idle_inputs();
            compare_value("commit[0].valid", commit[0].valid, 1'b0);
            compare_value("commit[1].valid", commit[1].valid, 1'b0);
        end
        send_result(0, m_q[0]);
        send_result(1, m_q[1]);
        @(negedge clk);
        idle_inputs();
        compare_value("commit[0].valid", commit[0].valid, 1'b1);
        compare_value("commit[1].valid", commit[1].valid, 1'b1);
        drain();
        report_test("head_of_line", err_start);

        // Full buffer refuses everything
        err_start = n_errors;
        allocate(rob_pkg::ROB_DEPTH);
        compare_value("count", count, rob_pkg::ROB_DEPTH);
        compare_value("full", full, 1'b1);
        repeat (4) begin
            @(negedge clk);
            alloc_req[0] = '{valid: 1'b1, dest: rand_dest()};
            @(posedge clk);
            compare_value("alloc_ok", alloc_ok, 1'b0);
        end
        @(negedge clk);
        idle_inputs();
        compare_value("count", count, rob_pkg::ROB_DEPTH);
        drain();
        report_test("full_buffer", err_start);

        // One free entry, pair refused, single taken
        err_start = n_errors;
        allocate(rob_pkg::ROB_DEPTH - 1);
        @(negedge clk);
        alloc_req[0] = '{valid: 1'b1, dest: rand_dest()};
        alloc_req[1] = '{valid: 1'b1, dest: rand_dest()};
        @(posedge clk);
        compare_value("alloc_ok", alloc_ok, 1'b0);
        @(negedge clk);
        idle_inputs();
        compare_value("count", count, rob_pkg::ROB_DEPTH - 1);
        exp_tail = m_tail;
        alloc_req[1] = '{valid: 1'b1, dest: rand_dest()};
        @(posedge clk);
        compare_value("alloc_ok", alloc_ok, 1'b1);
        compare_value("alloc_slot[1]", alloc_slot[1], exp_tail);
        @(negedge clk);
        idle_inputs();
        compare_value("count", count, rob_pkg::ROB_DEPTH);
        compare_value("full", full, 1'b1);
        drain();
        report_test("group_reject", err_start);

        // Fill and drain rounds across pointer wrap
        err_start = n_errors;
        repeat (6) begin
            allocate(7 + int'(rand_bits(3)));
            drain();
            @(negedge clk);
            compare_value("empty", empty, 1'b1);
            compare_value("count", count, 0);
        end
        report_test("occupancy", err_start);

        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 n_checks, n_errors, u_dut.u_props.fail_cnt);
        if (n_errors == 0 && u_dut.u_props.fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
src/rob_pkg.sv
src/rob_alloc_ctrl.sv
src/rob_entry_store.sv
src/rob_commit_ctrl.sv
src/rob_top.sv
tests/rob_properties.sv
tests/tb_rob.sv

// File: Bender.yml
package:
  name: rob

sources:
  - src/rob_pkg.sv
  - src/rob_alloc_ctrl.sv
  - src/rob_entry_store.sv
  - src/rob_commit_ctrl.sv
  - src/rob_top.sv
  - target: test
    files:
      - tests/rob_properties.sv
      - tests/tb_rob.sv
